//--- compile.f
+incdir+.
ddr_rx_pkg.sv
scl_edge_timer.sv
ddr_rx_shifter.sv
ddr_crc5.sv
ddr_rx_sequencer.sv
ddr_rx_top.sv
ddr_rx_tb.sv

//--- ddr_rx_tb.sv
// testbench for the HDR-DDR receive path, random frames from a target model with back-pressure
`timescale 1ns/1ps
`include "ddr_rx_macros.svh"

module ddr_rx_tb;

  import ddr_rx_pkg::*;

  localparam int NFRAMES   = 40;
  localparam int MAX_WORDS = 6;
  // data words are 20 bits each, the crc word 11 bits
  localparam int MAX_BITS  = MAX_WORDS * 20 + 11;
  // bound per frame covers SCL bits, ready stretches and field gaps
  localparam int FRAME_CYC = MAX_BITS * (`DDR_RX_SCL_HALF + 4) + MAX_WORDS * 2 * 20 + 64;
  localparam int CYC_LIMIT = NFRAMES * FRAME_CYC + 100;

  // frame fault kinds
  localparam int FAULT_NONE = 0;
  localparam int FAULT_PAR  = 1;
  localparam int FAULT_TOK  = 2;
  localparam int FAULT_CRC  = 3;
  localparam int FAULT_PRE  = 4;

  logic       i_sys_clk;
  logic       i_sys_rst;
  logic       i_sda;
  logic       o_scl;
  logic       i_start_valid;
  logic       o_start_ready;
  logic       o_byte_valid;
  byte_t      o_byte;
  logic       i_byte_ready;
  logic       o_stat_valid;
  rx_status_t o_stat;
  logic       i_stat_ready;

  logic [15:0] lfsr_state = 16'd57879;
  logic        frame_bits[$];
  byte_t       exp_bytes[$];
  rx_status_t  exp_stat;
  logic        stat_seen;
  logic        scl_last;
  logic [31:0] rnd_ready;
  int          hold_cnt;
  int          cycles;

  ddr_rx_top ddr_rx_top_inst (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_sda         (i_sda),
    .o_scl         (o_scl),
    .i_start_valid (i_start_valid),
    .o_start_ready (o_start_ready),
    .o_byte_valid  (o_byte_valid),
    .o_byte        (o_byte),
    .i_byte_ready  (i_byte_ready),
    .o_stat_valid  (o_stat_valid),
    .o_stat        (o_stat),
    .i_stat_ready  (i_stat_ready)
  );

  // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch, run stopped");
    end
  endtask

  // p1 from odd bits, p0 from even bits inverted
  function automatic par_t parity_model(input logic [15:0] w);
    logic p_odd;
    logic p_even;
    p_odd  = 1'b0;
    p_even = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      if (i % 2)
        p_odd = p_odd ^ w[i];
      else
        p_even = p_even ^ w[i];
    end
    return {p_odd, ~p_even};
  endfunction

  // x^5 + x^2 + 1, serial, msb first
  function automatic crc5_t crc5_model(input crc5_t c, input byte_t b);
    logic fb;
    for (int i = 7; i >= 0; i--)
    begin
      fb = c[4] ^ b[i];
      c  = {c[3], c[2], c[1] ^ fb, c[0], fb};
    end
    return c;
  endfunction

  task automatic push_field(input byte_t val, input int width);
    for (int i = width - 1; i >= 0; i--)
      frame_bits.push_back(val[i]);
  endtask

  // builds the bit stream plus the expected bytes and status
  task automatic build_frame(input int kind);
    logic [31:0] r;
    int          nwords;
    int          fault_word;
    logic        stop;
    byte_t       hi;
    byte_t       lo;
    par_t        par;
    crc5_t       crc;
    token_t      tok;
    frame_bits.delete();
    exp_bytes.delete();
    exp_stat = '0;
    stop     = 1'b0;
    crc      = `DDR_RX_CRC_INIT;
    take_bits(3, r);
    nwords = (r % MAX_WORDS) + 1;
    take_bits(3, r);
    fault_word = r % nwords;
    for (int k = 0; (k < nwords) && !stop; k++)
    begin
      take_bits(8, r);
      hi = r[7:0];
      take_bits(8, r);
      lo  = r[7:0];
      par = parity_model({hi, lo});
      if ((kind == FAULT_PRE) && (k == fault_word))
      begin
        // bad preamble, 00 or 10
        take_bits(1, r);
        push_field({6'b0, r[0], 1'b0}, 2);
        exp_stat.pre_err = 1'b1;
        stop             = 1'b1;
      end
      else
      begin
        push_field(8'h03, 2);
        push_field(hi, 8);
        push_field(lo, 8);
        exp_bytes.push_back(hi);
        exp_bytes.push_back(lo);
        crc = crc5_model(crc5_model(crc, hi), lo);
        if ((kind == FAULT_PAR) && (k == fault_word))
        begin
          take_bits(1, r);
          par              = par ^ (r[0] ? 2'b01 : 2'b10);
          exp_stat.par_err = 1'b1;
          stop             = 1'b1;
        end
        push_field({6'b0, par}, 2);
      end
    end
    if (!stop)
    begin
      // crc word
      push_field(8'h01, 2);
      tok = `DDR_RX_TOKEN;
      take_bits(4, r);
      if (kind == FAULT_TOK)
      begin
        tok              = tok ^ ((r[3:0] == 4'h0) ? 4'h1 : r[3:0]);
        exp_stat.tok_err = 1'b1;
      end
      push_field({4'b0, tok}, 4);
      take_bits(5, r);
      if (kind == FAULT_CRC)
      begin
        crc              = crc ^ ((r[4:0] == 5'h00) ? 5'h01 : r[4:0]);
        exp_stat.crc_err = 1'b1;
      end
      push_field({3'b0, crc}, 5);
    end
    exp_stat.byte_count = exp_bytes.size();
  endtask

  initial
  begin
    i_sys_clk = 1'b0;
    forever #5 i_sys_clk = ~i_sys_clk;
  end

  // target, next bit a little after each SCL toggle
  always @(o_scl)
  begin
    if (i_sys_rst)
    begin
      #2;
      i_sda = (frame_bits.size() > 0) ? frame_bits.pop_front() : 1'b1;
    end
  end

  // random ready stretches on the byte port, plain coin on status
  always @(posedge i_sys_clk)
  begin
    #1;
    if (hold_cnt == 0)
    begin
      take_bits(4, rnd_ready);
      hold_cnt = rnd_ready[3:0];
      take_bits(1, rnd_ready);
      i_byte_ready = rnd_ready[0];
    end
    else
      hold_cnt--;
    take_bits(1, rnd_ready);
    i_stat_ready = rnd_ready[0];
  end

  // byte and status checker
  always @(posedge i_sys_clk)
  begin
    if (i_sys_rst && o_byte_valid && i_byte_ready)
    begin
      if (exp_bytes.size() == 0)
        check_value("o_byte_valid", 1, 0);
      else
        check_value("o_byte", o_byte, exp_bytes.pop_front());
    end
    if (i_sys_rst && o_stat_valid && i_stat_ready)
    begin
      check_value("o_stat.pre_err", o_stat.pre_err, exp_stat.pre_err);
      check_value("o_stat.par_err", o_stat.par_err, exp_stat.par_err);
      check_value("o_stat.tok_err", o_stat.tok_err, exp_stat.tok_err);
      check_value("o_stat.crc_err", o_stat.crc_err, exp_stat.crc_err);
      check_value("o_stat.byte_count", o_stat.byte_count, exp_stat.byte_count);
      check_value("bytes_not_delivered", exp_bytes.size(), 0);
      stat_seen = 1'b1;
    end
  end

  // SCL must hold while a byte waits
  always @(negedge i_sys_clk)
  begin
    if (i_sys_rst && o_byte_valid)
      check_value("o_scl", o_scl, scl_last);
    scl_last = o_scl;
  end

  // run limit
  always @(posedge i_sys_clk)
  begin
    cycles++;
    if (cycles > CYC_LIMIT)
    begin
      $display("timeout, frames did not finish within %0d cycles", CYC_LIMIT);
      $display("Test FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  initial
  begin
    i_sys_rst     = 1'b0;
    i_sda         = 1'b1;
    i_start_valid = 1'b0;
    i_byte_ready  = 1'b0;
    i_stat_ready  = 1'b0;
    stat_seen     = 1'b0;
    scl_last      = 1'b1;
    hold_cnt      = 0;
    cycles        = 0;
    repeat (16) @(posedge i_sys_clk);
    #1;
    i_sys_rst = 1'b1;
    // reset values
    @(negedge i_sys_clk);
    check_value("o_scl", o_scl, 1);
    check_value("o_start_ready", o_start_ready, 1);
    check_value("o_byte_valid", o_byte_valid, 0);
    check_value("o_stat_valid", o_stat_valid, 0);
    for (int f = 0; f < NFRAMES; f++)
    begin
      // every fault kind comes up in turn
      build_frame(f % 5);
      stat_seen = 1'b0;
      @(posedge i_sys_clk);
      #1;
      i_start_valid = 1'b1;
      @(posedge i_sys_clk);
      while (!o_start_ready)
        @(posedge i_sys_clk);
      #1;
      i_start_valid = 1'b0;
      wait (stat_seen);
    end
    @(posedge i_sys_clk);
    $display("Test OK");
    $finish;
  end

endmodule

//--- ddr_rx_top.sv
// top of the HDR-DDR receive path, ties timer, shifter, crc and sequencer together
`timescale 1ns/1ps

module ddr_rx_top (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst,
  input  logic                   i_sda,
  output logic                   o_scl,
  input  logic                   i_start_valid,
  output logic                   o_start_ready,
  output logic                   o_byte_valid,
  output ddr_rx_pkg::byte_t      o_byte,
  input  logic                   i_byte_ready,
  output logic                   o_stat_valid,
  output ddr_rx_pkg::rx_status_t o_stat,
  input  logic                   i_stat_ready
);

  import ddr_rx_pkg::*;

  scl_edges_t edges;
  logic       run;
  rx_field_t  field;
  logic       field_start;
  field_res_t res;
  logic       byte_stb;
  byte_t      crc_byte;
  crc5_t      crc;
  logic       crc_clear;

  // SCL source
  scl_edge_timer scl_edge_timer_inst (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_run     (run),
    .o_scl     (o_scl),
    .o_edges   (edges)
  );

  // SDA sampling per field
  ddr_rx_shifter ddr_rx_shifter_inst (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_sda         (i_sda),
    .i_edges       (edges),
    .i_field       (field),
    .i_field_start (field_start),
    .o_res         (res),
    .o_byte_stb    (byte_stb),
    .o_byte        (crc_byte)
  );

  // running crc over the data bytes
  ddr_crc5 ddr_crc5_inst (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst  (i_sys_rst),
    .i_clear    (crc_clear),
    .i_byte_stb (byte_stb),
    .i_byte     (crc_byte),
    .o_crc      (crc)
  );

  // frame control and the two output streams
  ddr_rx_sequencer ddr_rx_sequencer_inst (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_start_valid (i_start_valid),
    .o_start_ready (o_start_ready),
    .i_res         (res),
    .i_crc         (crc),
    .o_run         (run),
    .o_field       (field),
    .o_field_start (field_start),
    .o_crc_clear   (crc_clear),
    .o_byte_valid  (o_byte_valid),
    .o_byte        (o_byte),
    .i_byte_ready  (i_byte_ready),
    .o_stat_valid  (o_stat_valid),
    .o_stat        (o_stat),
    .i_stat_ready  (i_stat_ready)
  );

endmodule

//--- ddr_rx_sequencer.sv
// frame FSM of the receive path, orders the fields, runs SCL, delivers bytes and reports status
`timescale 1ns/1ps

module ddr_rx_sequencer (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst,
  input  logic                   i_start_valid,
  output logic                   o_start_ready,
  input  ddr_rx_pkg::field_res_t i_res,
  input  ddr_rx_pkg::crc5_t      i_crc,
  output logic                   o_run,
  output ddr_rx_pkg::rx_field_t  o_field,
  output logic                   o_field_start,
  output logic                   o_crc_clear,
  output logic                   o_byte_valid,
  output ddr_rx_pkg::byte_t      o_byte,
  input  logic                   i_byte_ready,
  output logic                   o_stat_valid,
  output ddr_rx_pkg::rx_status_t o_stat,
  input  logic                   i_stat_ready
);

  import ddr_rx_pkg::*;

  rx_state_t  state;
  pre_t       rx_pre;
  crc5_t      rx_crc;
  rx_field_t  fld_next;
  logic       fld_deliver;
  logic       fld_finish;
  rx_status_t err_set;

  assign o_start_ready = (state == ST_IDLE);
  // SCL runs only while a field is being clocked
  assign o_run         = (state == ST_FIELD);

  assign rx_pre = i_res.value[PRE_W-1:0];
  assign rx_crc = i_res.value[CRC_W-1:0];

  // what the current field leads to
  always_comb
  begin
    fld_next    = o_field;
    fld_deliver = 1'b0;
    fld_finish  = 1'b0;
    err_set     = '0;
    case (o_field)
      FLD_PREAMBLE:
      begin
        if (rx_pre == 2'b11)
          fld_next = FLD_BYTE_HI;
        else if (rx_pre == 2'b01)
          fld_next = FLD_TOKEN;
        else
        begin
          err_set.pre_err = 1'b1;
          fld_finish      = 1'b1;
        end
      end
      FLD_BYTE_HI:
      begin
        fld_next    = FLD_BYTE_LO;
        fld_deliver = 1'b1;
      end
      FLD_BYTE_LO:
      begin
        fld_next    = FLD_PARITY;
        fld_deliver = 1'b1;
      end
      FLD_PARITY:
      begin
        fld_next        = FLD_PREAMBLE;
        err_set.par_err = i_res.err;
        fld_finish      = i_res.err;
      end
      FLD_TOKEN:
      begin
        fld_next        = FLD_CRC;
        err_set.tok_err = i_res.err;
        fld_finish      = i_res.err;
      end
      FLD_CRC:
      begin
        // last field either way
        err_set.crc_err = (rx_crc != i_crc);
        fld_finish      = 1'b1;
      end
      default:
      begin
        fld_finish = 1'b1;
      end
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      state         <= ST_IDLE;
      o_field       <= FLD_PREAMBLE;
      o_field_start <= 1'b0;
      o_crc_clear   <= 1'b0;
      o_byte_valid  <= 1'b0;
      o_stat_valid  <= 1'b0;
      o_stat        <= '0;
    end
    else
    begin
      o_field_start <= 1'b0;
      o_crc_clear   <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (i_start_valid)
          begin
            // new frame, fresh crc and status
            state         <= ST_FIELD;
            o_field       <= FLD_PREAMBLE;
            o_field_start <= 1'b1;
            o_crc_clear   <= 1'b1;
            o_stat        <= '0;
          end
        end
        ST_FIELD:
        begin
          if (i_res.done)
          begin
            o_field <= fld_next;
            o_stat  <= o_stat | err_set;
            if (fld_finish)
            begin
              // first error or crc word ends the frame
              state        <= ST_DONE;
              o_stat_valid <= 1'b1;
            end
            else if (fld_deliver)
            begin
              // SCL holds until the byte is taken
              state        <= ST_DELIVER;
              o_byte_valid <= 1'b1;
            end
            else
            begin
              o_field_start <= 1'b1;
            end
          end
        end
        ST_DELIVER:
        begin
          if (i_byte_ready)
          begin
            o_byte_valid      <= 1'b0;
            o_stat.byte_count <= o_stat.byte_count + 1'b1;
            state             <= ST_FIELD;
            o_field_start     <= 1'b1;
          end
        end
        ST_DONE:
        begin
          if (i_stat_ready)
          begin
            o_stat_valid <= 1'b0;
            state        <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // byte data, stable while valid waits
  always_ff @(posedge i_sys_clk)
  begin
    if ((state == ST_FIELD) && i_res.done && fld_deliver)
      o_byte <= i_res.value;
  end

endmodule

//--- ddr_crc5.sv
// CRC-5 accumulator over the data bytes of one frame, cleared by the sequencer at frame start
`timescale 1ns/1ps
`include "ddr_rx_macros.svh"

module ddr_crc5 (
  input  logic              i_sys_clk,
  input  logic              i_sys_rst,
  input  logic              i_clear,
  input  logic              i_byte_stb,
  input  ddr_rx_pkg::byte_t i_byte,
  output ddr_rx_pkg::crc5_t o_crc
);

  import ddr_rx_pkg::*;

  // eight serial steps unrolled, MSB first
  function automatic crc5_t crc5_byte(input crc5_t crc_in, input byte_t data);
    crc5_t crc;
    logic  fb;
    crc = crc_in;
    for (int i = BYTE_W - 1; i >= 0; i--)
    begin
      fb  = crc[CRC_W-1] ^ data[i];
      crc = {crc[CRC_W-2:0], 1'b0};
      if (fb)
        crc = crc ^ `DDR_RX_CRC_POLY;
    end
    return crc;
  endfunction

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
      o_crc <= `DDR_RX_CRC_INIT;
    // clear wins, never coincides with a byte anyway
    else if (i_clear)
      o_crc <= `DDR_RX_CRC_INIT;
    else if (i_byte_stb)
      o_crc <= crc5_byte(o_crc, i_byte);
  end

endmodule

//--- ddr_rx_shifter.sv
// SDA deserializer, takes one field per request from the sequencer and checks parity and token
`timescale 1ns/1ps
`include "ddr_rx_macros.svh"

module ddr_rx_shifter (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst,
  input  logic                   i_sda,
  input  ddr_rx_pkg::scl_edges_t i_edges,
  input  ddr_rx_pkg::rx_field_t  i_field,
  input  logic                   i_field_start,
  output ddr_rx_pkg::field_res_t o_res,
  output logic                   o_byte_stb,
  output ddr_rx_pkg::byte_t      o_byte
);

  import ddr_rx_pkg::*;

  // index of the last bit of each field
  function automatic logic [2:0] last_bit(input rx_field_t fld);
    case (fld)
      FLD_PREAMBLE: last_bit = 3'(PRE_W - 1);
      FLD_BYTE_HI:  last_bit = 3'(BYTE_W - 1);
      FLD_BYTE_LO:  last_bit = 3'(BYTE_W - 1);
      FLD_PARITY:   last_bit = 3'(PAR_W - 1);
      FLD_TOKEN:    last_bit = 3'(TOKEN_W - 1);
      FLD_CRC:      last_bit = 3'(CRC_W - 1);
      default:      last_bit = 3'(BYTE_W - 1);
    endcase
  endfunction

  logic        any_edge;
  logic        active;
  logic [2:0]  bit_cnt;
  logic        field_end;
  logic        is_byte;
  byte_t       shreg;
  byte_t       field_val;
  byte_t       word_hi;
  byte_t       word_lo;
  logic [15:0] word;
  par_t        par_calc;
  par_t        par_rx;
  token_t      tok_rx;

  // DDR, so both edges carry a bit
  assign any_edge = i_edges.pos | i_edges.neg;

  // shift in the current bit, MSB first
  // shreg is cleared at field start so narrow fields come out right-aligned
  assign field_val = {shreg[BYTE_W-2:0], i_sda};
  assign field_end = active && any_edge && (bit_cnt == last_bit(i_field));
  assign is_byte   = (i_field == FLD_BYTE_HI) || (i_field == FLD_BYTE_LO);

  // parity over the word just received
  // bit 1 from the odd bits, bit 0 from the even bits inverted
  assign word        = {word_hi, word_lo};
  assign par_calc[1] = ^(word & 16'hAAAA);
  assign par_calc[0] = ~^(word & 16'h5555);
  assign par_rx      = field_val[PAR_W-1:0];
  assign tok_rx      = field_val[TOKEN_W-1:0];

  // result is ready in the cycle of the last edge
  always_comb
  begin
    o_res.done  = field_end;
    o_res.value = field_val;
    o_res.err   = 1'b0;
    if (field_end)
    begin
      case (i_field)
        FLD_PARITY: o_res.err = (par_rx != par_calc);
        FLD_TOKEN:  o_res.err = (tok_rx != `DDR_RX_TOKEN);
        default:    o_res.err = 1'b0;
      endcase
    end
  end

  // bit counter, edges outside a field are ignored
  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      active     <= 1'b0;
      bit_cnt    <= '0;
      o_byte_stb <= 1'b0;
    end
    else
    begin
      o_byte_stb <= field_end && is_byte;
      if (i_field_start)
      begin
        active  <= 1'b1;
        bit_cnt <= '0;
      end
      else if (active && any_edge)
      begin
        if (field_end)
          active <= 1'b0;
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // shift register and word bytes
  always_ff @(posedge i_sys_clk)
  begin
    if (i_field_start)
      shreg <= '0;
    else if (active && any_edge)
      shreg <= field_val;
    if (field_end && (i_field == FLD_BYTE_HI))
      word_hi <= field_val;
    if (field_end && (i_field == FLD_BYTE_LO))
      word_lo <= field_val;
    // copy for the crc, goes with o_byte_stb
    if (field_end && is_byte)
      o_byte <= field_val;
  end

endmodule

//--- scl_edge_timer.sv
// SCL generator for the receive path, divides the system clock and strobes every SCL edge
`timescale 1ns/1ps
`include "ddr_rx_macros.svh"

module scl_edge_timer (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst,
  input  logic                   i_run,
  output logic                   o_scl,
  output ddr_rx_pkg::scl_edges_t o_edges
);

  // phase counter wide enough for the half period, never zero bits
  localparam int PHASE_W = ($clog2(`DDR_RX_SCL_HALF) > 0) ? $clog2(`DDR_RX_SCL_HALF) : 1;
  localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`DDR_RX_SCL_HALF - 1);

  logic [PHASE_W-1:0] phase;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      phase   <= '0;
      // bus idles with SCL high
      o_scl   <= 1'b1;
      o_edges <= '0;
    end
    else
    begin
      // strobes last a single cycle
      o_edges <= '0;
      if (!i_run)
      begin
        // stopped, level kept, next half period starts fresh
        phase <= '0;
      end
      else if (phase == PHASE_LAST)
      begin
        phase       <= '0;
        o_scl       <= ~o_scl;
        // strobe lines up with the new SCL level
        o_edges.pos <= ~o_scl;
        o_edges.neg <= o_scl;
      end
      else
      begin
        phase <= phase + 1'b1;
      end
    end
  end

endmodule

//--- ddr_rx_pkg.sv
// types shared by the HDR-DDR receive RTL, imported by each block that uses them
package ddr_rx_pkg;

  // field widths on the wire
  localparam int BYTE_W  = 8;
  localparam int CRC_W   = 5;
  localparam int TOKEN_W = 4;
  localparam int PAR_W   = 2;
  localparam int PRE_W   = 2;
  localparam int COUNT_W = 8;

  typedef logic [BYTE_W-1:0]  byte_t;
  typedef logic [CRC_W-1:0]   crc5_t;
  typedef logic [TOKEN_W-1:0] token_t;
  typedef logic [PAR_W-1:0]   par_t;
  typedef logic [PRE_W-1:0]   pre_t;

  // field the shifter takes next
  typedef enum logic [2:0] {
    FLD_PREAMBLE,
    FLD_BYTE_HI,
    FLD_BYTE_LO,
    FLD_PARITY,
    FLD_TOKEN,
    FLD_CRC
  } rx_field_t;

  // frame sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FIELD,
    ST_DELIVER,
    ST_DONE
  } rx_state_t;

  // one-cycle strobes, one per SCL edge
  typedef struct packed {
    logic pos;
    logic neg;
  } scl_edges_t;

  // result of one field, value right-aligned
  typedef struct packed {
    logic  done;
    byte_t value;
    logic  err;
  } field_res_t;

  // end-of-frame record
  typedef struct packed {
    logic               pre_err;
    logic               par_err;
    logic               tok_err;
    logic               crc_err;
    logic [COUNT_W-1:0] byte_count;
  } rx_status_t;

endpackage

//--- ddr_rx_macros.svh
// shared constants for the HDR-DDR receive path, included by the RTL files that need them
`ifndef DDR_RX_MACROS_SVH
`define DDR_RX_MACROS_SVH

// system clocks per SCL half period
// at least 2, so a field end can stop SCL before the next edge
`define DDR_RX_SCL_HALF 4

// fixed token that opens the CRC word
`define DDR_RX_TOKEN 4'hC

// crc-5 polynomial x^5 + x^2 + 1, top bit implied
`define DDR_RX_CRC_POLY 5'h05

// crc-5 seed loaded at frame start
`define DDR_RX_CRC_INIT 5'h1F

`endif
